// ==== rtl/ip_mux_pkg.sv ====
`default_nettype none

package ip_mux_pkg;

    // source ports and widths
    localparam int src_count     = 4;
    localparam int src_sel_width = 2;
    localparam int data_width    = 8;

    typedef logic [src_sel_width-1:0] src_sel_t;
    typedef logic [src_count-1:0]     src_mask_t;

    // ethernet header followed by the ipv4 header, 272 bits
    typedef struct packed {
        logic [47:0] eth_dest_mac;
        logic [47:0] eth_src_mac;
        logic [15:0] eth_type;
        logic [3:0]  version;
        logic [3:0]  ihl;
        logic [5:0]  dscp;
        logic [1:0]  ecn;
        logic [15:0] length;
        logic [15:0] identification;
        logic [2:0]  flags;
        logic [12:0] fragment_offset;
        logic [7:0]  ttl;
        logic [7:0]  protocol;
        logic [15:0] header_checksum;
        logic [31:0] source_ip;
        logic [31:0] dest_ip;
    } ip_hdr_t;

    // one payload byte with its frame marker and user bit
    typedef struct packed {
        logic [data_width-1:0] data;
        logic                  last;
        logic                  user;
    } payload_beat_t;

endpackage

`default_nettype wire

// ==== rtl/ip_frame_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module ip_frame_ctrl import ip_mux_pkg::*; (
    input  wire logic      clk,
    input  wire logic      rst,
    input  wire logic      enable,
    input  wire src_sel_t  select,
    input  wire src_mask_t s_hdr_valid,
    input  wire logic      hdr_busy,
    input  wire logic      last_taken,
    output logic           start,
    output src_sel_t       cur_sel,
    output logic           in_frame
);

    src_sel_t sel_reg;

    // a frame may only begin when idle and the header slot is free
    assign start = enable && !in_frame && !hdr_busy && s_hdr_valid[select];

    // next port choice, follows select only on the start edge
    assign cur_sel = start ? select : sel_reg;

    always_ff @(posedge clk) begin
        if (rst) begin
            in_frame <= 1'b0;
            sel_reg  <= '0;
        end else begin
            if (start) begin
                in_frame <= 1'b1;
                sel_reg  <= select;
            end else if (last_taken) begin
                // last beat accepted so the port is released
                in_frame <= 1'b0;
            end
        end
    end

    // the lock holds after a start and no second start can follow directly
    assert property (@(posedge clk) disable iff (rst)
        start |=> (in_frame && !start))
        else $error("frame start while a frame is in progress");

    // the payload path must only finish a frame that was opened here
    assert property (@(posedge clk) disable iff (rst)
        last_taken |-> in_frame)
        else $error("last beat taken outside a frame");

endmodule

`default_nettype wire

// ==== rtl/ip_hdr_capture.sv ====
`timescale 1ns/1ps
`default_nettype none

module ip_hdr_capture import ip_mux_pkg::*; (
    input  wire logic                     clk,
    input  wire logic                     rst,
    input  wire logic                     start,
    input  wire src_sel_t                 cur_sel,
    input  wire ip_hdr_t [src_count-1:0]  s_hdr,
    input  wire logic                     m_hdr_ready,
    output src_mask_t                     s_hdr_ready,
    output logic                          m_hdr_valid,
    output ip_hdr_t                       m_hdr,
    output logic                          hdr_busy
);

    // output slot is occupied until the sink takes the header
    assign hdr_busy = m_hdr_valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            m_hdr_valid <= 1'b0;
            s_hdr_ready <= '0;
        end else begin
            s_hdr_ready <= '0;
            if (start) begin
                m_hdr_valid <= 1'b1;
                // acknowledge the chosen source one cycle after capture
                s_hdr_ready <= src_mask_t'(1) << cur_sel;
            end else if (m_hdr_ready) begin
                m_hdr_valid <= 1'b0;
            end
        end
    end

    // header register, loaded only at the start of a frame
    always_ff @(posedge clk) begin
        if (start) begin
            m_hdr <= s_hdr[cur_sel];
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        $onehot0(s_hdr_ready))
        else $error("more than one header ready bit");

    // ready is a single isolated pulse, seen while the header is presented
    assert property (@(posedge clk) disable iff (rst)
        (s_hdr_ready != '0) |-> m_hdr_valid ##1 (s_hdr_ready == '0))
        else $error("header ready is not a one cycle pulse");

    // a held header does not change under back-pressure
    assert property (@(posedge clk) disable iff (rst)
        (m_hdr_valid && !m_hdr_ready) |=> (m_hdr_valid && $stable(m_hdr)))
        else $error("header changed while stalled");

endmodule

`default_nettype wire

// ==== rtl/ip_payload_steer.sv ====
`timescale 1ns/1ps
`default_nettype none

module ip_payload_steer import ip_mux_pkg::*; (
    input  wire logic                          clk,
    input  wire logic                          rst,
    input  wire src_sel_t                      cur_sel,
    input  wire logic                          in_frame,
    input  wire payload_beat_t [src_count-1:0] s_payload,
    input  wire src_mask_t                     s_payload_valid,
    input  wire logic                          ready_early,
    output src_mask_t                          s_payload_ready,
    output payload_beat_t                      beat,
    output logic                               beat_valid,
    output logic                               last_taken
);

    logic frame_next;

    // frame stays open unless its last beat goes through this cycle
    assign frame_next = in_frame && !last_taken;

    // the latched source is the only one looked at
    assign beat       = s_payload[cur_sel];
    assign beat_valid = in_frame && s_payload_valid[cur_sel] && s_payload_ready[cur_sel];
    assign last_taken = beat_valid && beat.last;

    always_ff @(posedge clk) begin
        if (rst) begin
            s_payload_ready <= '0;
        end else if (ready_early && frame_next) begin
            s_payload_ready <= src_mask_t'(1) << cur_sel;
        end else begin
            s_payload_ready <= '0;
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        $onehot0(s_payload_ready))
        else $error("more than one payload ready bit");

    // a source is never granted outside the frame that owns the port
    assert property (@(posedge clk) disable iff (rst)
        (s_payload_ready != '0) |-> in_frame)
        else $error("payload ready outside a frame");

endmodule

`default_nettype wire

// ==== rtl/ip_payload_skid.sv ====
`timescale 1ns/1ps
`default_nettype none

module ip_payload_skid import ip_mux_pkg::*; (
    input  wire logic          clk,
    input  wire logic          rst,
    input  wire payload_beat_t beat,
    input  wire logic          beat_valid,
    input  wire logic          m_payload_ready,
    output logic               ready_early,
    output payload_beat_t      m_payload,
    output logic               m_payload_valid
);

    payload_beat_t out_reg;
    payload_beat_t temp_reg;
    logic          out_valid;
    logic          out_valid_next;
    logic          temp_valid;
    logic          temp_valid_next;
    logic          ready_reg;

    logic          store_in_to_out;
    logic          store_in_to_temp;
    logic          store_temp_to_out;

    assign m_payload       = out_reg;
    assign m_payload_valid = out_valid;

    // space next cycle if the sink drains now, or the temp register
    // cannot fill on this edge
    assign ready_early = m_payload_ready || (!temp_valid && (!out_valid || !beat_valid));

    always_comb begin
        out_valid_next    = out_valid;
        temp_valid_next   = temp_valid;
        store_in_to_out   = 1'b0;
        store_in_to_temp  = 1'b0;
        store_temp_to_out = 1'b0;

        if (ready_reg) begin
            if (m_payload_ready || !out_valid) begin
                // output register free, incoming beat goes straight there
                out_valid_next  = beat_valid;
                store_in_to_out = 1'b1;
            end else begin
                // output stalled, park the beat
                temp_valid_next  = beat_valid;
                store_in_to_temp = 1'b1;
            end
        end else if (m_payload_ready) begin
            // no input this cycle, refill from temp
            out_valid_next    = temp_valid;
            temp_valid_next   = 1'b0;
            store_temp_to_out = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid  <= 1'b0;
            temp_valid <= 1'b0;
            ready_reg  <= 1'b0;
        end else begin
            out_valid  <= out_valid_next;
            temp_valid <= temp_valid_next;
            ready_reg  <= ready_early;
        end
    end

    always_ff @(posedge clk) begin
        if (store_in_to_out) begin
            out_reg <= beat;
        end else if (store_temp_to_out) begin
            out_reg <= temp_reg;
        end

        if (store_in_to_temp) begin
            temp_reg <= beat;
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        (m_payload_valid && !m_payload_ready) |=> (m_payload_valid && $stable(m_payload)))
        else $error("payload beat changed while stalled");

endmodule

`default_nettype wire

// ==== rtl/ip_mux.sv ====
`timescale 1ns/1ps
`default_nettype none

module ip_mux import ip_mux_pkg::*; (
    input  wire logic                          clk,
    input  wire logic                          rst,

    // sources
    input  wire src_mask_t                     s_hdr_valid,
    output src_mask_t                          s_hdr_ready,
    input  wire ip_hdr_t [src_count-1:0]       s_hdr,
    input  wire payload_beat_t [src_count-1:0] s_payload,
    input  wire src_mask_t                     s_payload_valid,
    output src_mask_t                          s_payload_ready,

    // merged output
    output logic                               m_hdr_valid,
    input  wire logic                          m_hdr_ready,
    output ip_hdr_t                            m_hdr,
    output logic                               m_payload_valid,
    input  wire logic                          m_payload_ready,
    output payload_beat_t                      m_payload,

    // control
    input  wire logic                          enable,
    input  wire src_sel_t                      select
);

    logic          start;
    src_sel_t      cur_sel;
    logic          in_frame;
    logic          hdr_busy;
    logic          last_taken;
    payload_beat_t beat;
    logic          beat_valid;
    logic          ready_early;

    ip_frame_ctrl frame_ctrl_inst (
        .clk         (clk),
        .rst         (rst),
        .enable      (enable),
        .select      (select),
        .s_hdr_valid (s_hdr_valid),
        .hdr_busy    (hdr_busy),
        .last_taken  (last_taken),
        .start       (start),
        .cur_sel     (cur_sel),
        .in_frame    (in_frame)
    );

    ip_hdr_capture hdr_capture_inst (
        .clk         (clk),
        .rst         (rst),
        .start       (start),
        .cur_sel     (cur_sel),
        .s_hdr       (s_hdr),
        .m_hdr_ready (m_hdr_ready),
        .s_hdr_ready (s_hdr_ready),
        .m_hdr_valid (m_hdr_valid),
        .m_hdr       (m_hdr),
        .hdr_busy    (hdr_busy)
    );

    ip_payload_steer payload_steer_inst (
        .clk             (clk),
        .rst             (rst),
        .cur_sel         (cur_sel),
        .in_frame        (in_frame),
        .s_payload       (s_payload),
        .s_payload_valid (s_payload_valid),
        .ready_early     (ready_early),
        .s_payload_ready (s_payload_ready),
        .beat            (beat),
        .beat_valid      (beat_valid),
        .last_taken      (last_taken)
    );

    ip_payload_skid payload_skid_inst (
        .clk             (clk),
        .rst             (rst),
        .beat            (beat),
        .beat_valid      (beat_valid),
        .m_payload_ready (m_payload_ready),
        .ready_early     (ready_early),
        .m_payload       (m_payload),
        .m_payload_valid (m_payload_valid)
    );

endmodule

`default_nettype wire

// ==== bench/tb_ip_mux.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_ip_mux import ip_mux_pkg::*; ();

    localparam string pattern_file = "bench/ip_mux_patterns.txt";
    localparam int    max_frames   = 64;
    localparam int    margin       = 20;
    localparam int    gate_frame   = 2;
    localparam int    gate_cycles  = 10;

    logic                          clk;
    logic                          rst;
    logic                          enable;
    src_sel_t                      select;
    src_mask_t                     s_hdr_valid;
    src_mask_t                     s_hdr_ready;
    ip_hdr_t [src_count-1:0]       s_hdr;
    payload_beat_t [src_count-1:0] s_payload;
    src_mask_t                     s_payload_valid;
    src_mask_t                     s_payload_ready;
    logic                          m_hdr_valid;
    logic                          m_hdr_ready;
    ip_hdr_t                       m_hdr;
    logic                          m_payload_valid;
    logic                          m_payload_ready;
    payload_beat_t                 m_payload;

    // frame table filled from the pattern file
    src_sel_t   pat_port  [max_frames];
    ip_hdr_t    pat_hdr   [max_frames];
    int         pat_len   [max_frames];
    logic [7:0] pat_first [max_frames];
    logic       pat_user  [max_frames];
    int         frame_count;
    int         max_len;

    int          hdr_seen;
    int          frames_seen;
    int          beat_idx;
    logic [31:0] rng_state;

    initial clk = 1'b0;
    always #10 clk = ~clk;

    ip_mux ip_mux_inst (
        .clk             (clk),
        .rst             (rst),
        .s_hdr_valid     (s_hdr_valid),
        .s_hdr_ready     (s_hdr_ready),
        .s_hdr           (s_hdr),
        .s_payload       (s_payload),
        .s_payload_valid (s_payload_valid),
        .s_payload_ready (s_payload_ready),
        .m_hdr_valid     (m_hdr_valid),
        .m_hdr_ready     (m_hdr_ready),
        .m_hdr           (m_hdr),
        .m_payload_valid (m_payload_valid),
        .m_payload_ready (m_payload_ready),
        .m_payload       (m_payload),
        .enable          (enable),
        .select          (select)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // byte k counts up from the first byte and user rides on the last beat
    function automatic payload_beat_t expected_beat(input int f, input int k);
        payload_beat_t b;
        b.data = pat_first[f] + 8'(k);
        b.last = (k == pat_len[f] - 1);
        b.user = b.last ? pat_user[f] : 1'b0;
        return b;
    endfunction

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("Checks failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_hdr(input string name, input ip_hdr_t got, input ip_hdr_t exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("Mismatch at %0t: %s got %h expected %h",
                $time, name, got, exp));
        end
    endtask

    task automatic check_beat(input string name, input payload_beat_t got,
                              input payload_beat_t exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("Mismatch at %0t: %s got %h expected %h",
                $time, name, got, exp));
        end
    endtask

    task automatic check_mask(input string name, input src_mask_t got, input src_mask_t exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("Mismatch at %0t: %s got %b expected %b",
                $time, name, got, exp));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("Mismatch at %0t: %s got %b expected %b",
                $time, name, got, exp));
        end
    endtask

    // only the frame's own source may see a ready bit
    task automatic check_grants(input src_sel_t src, input logic hdr_phase);
        src_mask_t own;
        own = src_mask_t'(1) << src;
        check_mask("s_hdr_ready (other ports)", s_hdr_ready & (hdr_phase ? ~own : '1), '0);
        check_mask("s_payload_ready (other ports)", s_payload_ready & ~own, '0);
    endtask

    task automatic load_patterns();
        int          fd;
        int          n;
        string       line;
        logic [47:0] fld [20];
        fd = $fopen(pattern_file, "r");
        if (fd == 0) begin
            stop_with_failure("cannot open the pattern file");
        end
        frame_count = 0;
        max_len     = 0;
        while (!$feof(fd) && frame_count < max_frames) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 1 && line[0] != "#") begin
                n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    fld[0], fld[1], fld[2], fld[3], fld[4], fld[5], fld[6], fld[7],
                    fld[8], fld[9], fld[10], fld[11], fld[12], fld[13], fld[14],
                    fld[15], fld[16], fld[17], fld[18], fld[19]);
                if (n != 20 || fld[17] == '0) begin
                    stop_with_failure($sformatf("unreadable pattern line: %s", line));
                end
                pat_port[frame_count]  = fld[0][1:0];
                pat_hdr[frame_count]   = {fld[1], fld[2], fld[3][15:0], fld[4][3:0],
                    fld[5][3:0], fld[6][5:0], fld[7][1:0], fld[8][15:0], fld[9][15:0],
                    fld[10][2:0], fld[11][12:0], fld[12][7:0], fld[13][7:0],
                    fld[14][15:0], fld[15][31:0], fld[16][31:0]};
                pat_len[frame_count]   = int'(fld[17]);
                pat_first[frame_count] = fld[18][7:0];
                pat_user[frame_count]  = fld[19][0];
                if (pat_len[frame_count] > max_len) begin
                    max_len = pat_len[frame_count];
                end
                frame_count++;
            end
        end
        $fclose(fd);
        if (frame_count == 0) begin
            stop_with_failure("the pattern file holds no frames");
        end
    endtask

    task automatic send_frame(input int f);
        src_sel_t src;
        src_sel_t dummy;
        int       k;
        src   = pat_port[f];
        dummy = src + src_sel_t'(1);
        if (f == gate_frame) begin
            // gate first and then let the previous header drain
            enable = 1'b0;
            while (m_hdr_valid) @(negedge clk);
        end
        s_hdr_valid            = '0;
        s_payload_valid        = '0;
        s_hdr[src]             = pat_hdr[f];
        s_hdr[dummy]           = ~pat_hdr[f];
        s_payload[dummy]       = {~pat_first[f], 1'b1, 1'b1};
        s_hdr_valid[src]       = 1'b1;
        s_hdr_valid[dummy]     = 1'b1;
        s_payload_valid[dummy] = 1'b1;
        select                 = src;
        if (f == gate_frame) begin
            repeat (gate_cycles) begin
                @(negedge clk);
                check_bit("m_hdr_valid", m_hdr_valid, 1'b0);
                check_mask("s_hdr_ready", s_hdr_ready, '0);
            end
            enable = 1'b1;
        end
        while (!s_hdr_ready[src]) begin
            @(negedge clk);
            check_grants(src, 1'b1);
        end
        // header handshake completes on the coming rising edge
        @(negedge clk);
        s_hdr_valid[src] = 1'b0;
        for (k = 0; k < pat_len[f]; k++) begin
            if (k == pat_len[f] / 2 && k != pat_len[f] - 1) begin
                select = dummy;
            end
            if (k == pat_len[f] - 1) begin
                select = src;
            end
            s_payload[src]       = expected_beat(f, k);
            s_payload_valid[src] = 1'b1;
            while (!s_payload_ready[src]) begin
                @(negedge clk);
                check_grants(src, 1'b0);
            end
            @(negedge clk);
            check_grants(src, 1'b0);
        end
        s_payload_valid[src] = 1'b0;
    endtask

    // random sink with header and payload checks at each accepted transfer
    task automatic run_sink();
        forever begin
            @(negedge clk);
            rng_state       = xorshift32(rng_state);
            m_hdr_ready     = rng_state[3];
            m_payload_ready = rng_state[9];
            if (m_hdr_valid && m_hdr_ready) begin
                if (hdr_seen >= frame_count) begin
                    stop_with_failure("a header came out after the last frame");
                end else begin
                    check_hdr("m_hdr", m_hdr, pat_hdr[hdr_seen]);
                    hdr_seen++;
                end
            end
            if (m_payload_valid && m_payload_ready) begin
                if (frames_seen >= frame_count) begin
                    stop_with_failure("a payload beat came out after the last frame");
                end else begin
                    check_beat("m_payload", m_payload, expected_beat(frames_seen, beat_idx));
                    beat_idx++;
                    if (beat_idx == pat_len[frames_seen]) begin
                        frames_seen++;
                        beat_idx = 0;
                    end
                end
            end
        end
    endtask

    task automatic run_watchdog(input int cycles);
        repeat (cycles) @(posedge clk);
        stop_with_failure($sformatf("timeout: frames not done after %0d cycles", cycles));
    endtask

    initial begin
        int f;
        rst             = 1'b1;
        enable          = 1'b1;
        select          = '0;
        s_hdr_valid     = '0;
        s_hdr           = '0;
        s_payload       = '0;
        s_payload_valid = '0;
        m_hdr_ready     = 1'b0;
        m_payload_ready = 1'b0;
        rng_state       = 32'd45;
        hdr_seen        = 0;
        frames_seen     = 0;
        beat_idx        = 0;
        load_patterns();
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        check_bit("m_hdr_valid", m_hdr_valid, 1'b0);
        check_bit("m_payload_valid", m_payload_valid, 1'b0);
        check_mask("s_hdr_ready", s_hdr_ready, '0);
        check_mask("s_payload_ready", s_payload_ready, '0);
        fork
            run_sink();
            run_watchdog(frame_count * (max_len + margin) * 4);
        join_none
        for (f = 0; f < frame_count; f++) begin
            send_frame(f);
        end
        s_hdr_valid     = '0;
        s_payload_valid = '0;
        while (hdr_seen < frame_count || frames_seen < frame_count) @(posedge clk);
        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== ip_mux.f ====
rtl/ip_mux_pkg.sv
rtl/ip_frame_ctrl.sv
rtl/ip_hdr_capture.sv
rtl/ip_payload_steer.sv
rtl/ip_payload_skid.sv
rtl/ip_mux.sv
bench/tb_ip_mux.sv

// ==== Makefile ====
# Verilator build and run of the ip_mux testbench

VERILATOR ?= verilator
TOP       ?= tb_ip_mux
FILELIST  ?= ip_mux.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
PASS_TEXT ?= All checks passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   show this list"
	@echo "  test   build with Verilator, run the testbench, search the log for the pass line"
	@echo "  clean  remove the build directory and the log"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS PASS_TEXT"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(PASS_TEXT)" $(LOG); then \
		echo "test passed"; \
	else \
		echo "test failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== bench/ip_mux_patterns.txt ====
# port dmac smac etype ver ihl dscp ecn len id flags frag ttl proto csum sip dip
# then payload length, first byte, user bit; every field is hex
0 020000000001 020000000a00 0800 4 5 00 0 002e 0001 2 0000 40 11 b861 c0a80101 c0a80102 05 10 1
1 020000000002 020000000a01 0800 4 5 2e 1 0040 0002 0 0000 3f 06 1c3a c0a80103 0a000001 01 7f 0
2 ffffffffffff 020000000a02 0800 4 5 00 0 0100 1234 1 0abc 80 11 ffff 0a000002 e0000001 08 fc 1
3 0a1b2c3d4e5f 665544332211 0800 4 6 3f 3 0020 beef 7 1fff 01 01 0000 ac100001 ac100002 10 00 0
3 00005e000101 020000000a03 0800 4 5 12 2 05dc 0003 2 0000 40 06 a5a5 c0a80001 c0a80002 03 f0 1
0 01005e000001 020000000a04 0800 4 5 08 0 001c 0004 0 0001 01 02 5a5a c0a80164 e00000fb 02 aa 0
2 3c5a7e9fb1d3 020000000a05 0800 4 7 1a 1 0230 7fff 3 0100 ff 11 0f0f 08080808 08080404 0c 33 1
1 123456789abc 020000000a06 0800 4 5 00 3 0064 8000 2 0000 40 11 f00d 0a0a0a0a 0a0a0a0b 07 fe 0
1 deadbeef0001 020000000a07 0800 4 5 04 0 0400 0005 0 0200 20 06 c0de c0a80a01 c0a80a02 01 01 1
3 020000000010 020000000a08 0800 4 8 30 2 1000 0006 1 0fff 7f 11 1234 ac10ff01 ac10ff02 0f 80 0
0 020000000011 020000000a09 0800 4 5 00 0 0032 0007 2 0000 40 01 4321 c0a80201 c0a80202 04 20 1
2 020000000012 020000000a0a 0800 4 5 0a 1 0048 0008 2 0000 40 06 9999 c0a80301 c0a80302 09 f8 0
2 020000000013 020000000a0b 0800 4 5 00 0 0030 0009 0 0000 10 11 8888 c0a80401 c0a80402 06 44 1
0 020000000014 020000000a0c 0800 4 f 3f 3 ffff ffff 7 1fff ff ff 7777 ffffffff 00000000 10 c0 1
3 020000000015 020000000a0d 0800 4 5 00 0 0022 000a 2 0000 40 11 6666 0a010101 0a010102 02 55 0
1 020000000016 020000000a0e 0800 4 5 1c 2 0050 000b 2 0000 40 06 5555 0a020201 0a020202 0b 9a 1
0 020000000017 020000000a0f 0800 4 5 00 1 0026 000c 0 0000 40 11 4444 0a030301 0a030302 03 e0 0
1 020000000018 020000000a10 0800 4 5 2a 0 0080 000d 2 0000 40 06 3333 0a040401 0a040402 0e 6b 1
3 020000000019 020000000a11 0800 4 5 00 0 002a 000e 2 0000 40 11 2222 0a050501 0a050502 05 fb 0
2 02000000001a 020000000a12 0800 4 5 10 3 001d 000f 1 0010 40 01 1111 0a060601 0a060602 01 ff 1
1 02000000001b 020000000a13 0800 4 5 00 0 003c 0010 2 0000 40 06 abcd 0a070701 0a070702 0a 0f 0
0 02000000001c 020000000a14 86dd 0 0 00 0 0000 0000 0 0000 00 00 0000 00000000 00000001 06 a0 1
